/* design/cpu_pkg.sv */
package cpu_pkg;

  localparam int word_w     = 16;
  localparam int addr_w     = 8;   // 256-word ram
  localparam int page_off_w = 5;   // 32 words per page
  localparam int phys_pages = 8;
  localparam int reg_count  = 16;
  localparam int reg_sel_w  = $clog2(reg_count);
  localparam int page_w     = word_w - page_off_w;  // logical page bits
  localparam int ppage_w    = addr_w - page_off_w;  // physical page bits
  localparam int tag_w      = page_w + 1;           // logical page plus one, 0 = free

  localparam logic [7:0] op_jmp            = 8'd1;
  localparam logic [7:0] op_ram2reg        = 8'd2;
  localparam logic [7:0] op_reg2ram        = 8'd3;
  localparam logic [7:0] op_num2reg        = 8'd4;
  localparam logic [7:0] op_reg_plus       = 8'd5;
  localparam logic [7:0] op_reg_minus      = 8'd6;
  localparam logic [7:0] op_till_value     = 8'd9;
  localparam logic [7:0] op_till_non_value = 8'd10;
  localparam logic [7:0] op_loop           = 8'd11;
  localparam logic [7:0] op_exit           = 8'd17;

  localparam logic [1:0] lk_till_value     = 2'd0;
  localparam logic [1:0] lk_till_non_value = 2'd1;
  localparam logic [1:0] lk_counted        = 2'd2;

  // sequencer states
  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_xlate  = 3'd1;  // map request out
  localparam logic [2:0] st_xwait  = 3'd2;  // waiting for translation
  localparam logic [2:0] st_ram    = 3'd3;  // ram access issued
  localparam logic [2:0] st_load   = 3'd4;  // read data valid
  localparam logic [2:0] st_exec   = 3'd5;
  localparam logic [2:0] st_retire = 3'd6;
  localparam logic [2:0] st_halt   = 3'd7;

  // what the current translation is for
  localparam logic [1:0] xk_head = 2'd0;
  localparam logic [1:0] xk_opnd = 2'd1;
  localparam logic [1:0] xk_data = 2'd2;

  localparam logic [1:0] mp_idle  = 2'd0;
  localparam logic [1:0] mp_walk  = 2'd1;
  localparam logic [1:0] mp_probe = 2'd2;

  typedef logic [word_w-1:0] word_t;

  typedef struct packed {
    logic [page_w-1:0]     page;
    logic [page_off_w-1:0] offset;
  } logical_addr_t;

  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] reg_field;
  } inst_head_t;

  typedef struct packed {
    logic [7:0] comp_value;
    logic [7:0] count;
  } loop_operand_t;

  // second instruction word, loops read it split in two
  typedef union packed {
    word_t         imm;
    loop_operand_t loop;
  } operand_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    word_t             data;
  } load_t;

  typedef struct packed {
    logical_addr_t laddr;
  } map_req_t;

  typedef struct packed {
    logic [addr_w-1:0] phys_addr;
    logic              fault;
  } map_resp_t;

  typedef struct packed {
    word_t                pc;
    logic [7:0]           opcode;
    logic [reg_sel_w-1:0] reg_num;
    word_t                result;
    logic [addr_w-1:0]    phys_addr;
  } retire_t;

endpackage

/* design/program_ram.sv */
module program_ram (
  input  logic                       clka,
  input  logic                       rst,
  input  logic                       busy,
  input  logic                       load_valid,
  input  cpu_pkg::load_t             load,
  output logic                       load_ready,
  input  logic                       ram_en,
  input  logic                       ram_we,
  input  logic [cpu_pkg::addr_w-1:0] ram_addr,
  input  cpu_pkg::word_t             ram_wdata,
  output cpu_pkg::word_t             ram_rdata
);

  cpu_pkg::word_t mem [2**cpu_pkg::addr_w];

  // load port owns the ram until the core starts
  always_ff @(posedge clka) begin
    if (!rst) begin
      load_ready <= 1'b1;
    end else begin
      load_ready <= !busy;
    end
  end

  always_ff @(posedge clka) begin
    if (load_ready) begin
      if (load_valid) begin
        mem[load.addr] <= load.data;
      end
    end else if (ram_en && ram_we) begin
      mem[ram_addr] <= ram_wdata;  // reg2ram store
    end
  end

  always_ff @(posedge clka) begin
    if (ram_en) begin
      ram_rdata <= mem[ram_addr];  // one cycle read latency
    end
  end

endmodule

/* design/page_mapper.sv */
module page_mapper (
  input  logic                clka,
  input  logic                rst,
  input  logic                start,
  input  logic                map_req_valid,
  input  cpu_pkg::map_req_t   map_req,
  output logic                map_req_ready,
  output logic                map_resp_valid,
  output cpu_pkg::map_resp_t  map_resp
);

  logic [cpu_pkg::ppage_w-1:0]    chain [cpu_pkg::phys_pages];  // next page, 0 ends chain
  logic [cpu_pkg::tag_w-1:0]      tag   [cpu_pkg::phys_pages];  // owner page + 1
  logic [1:0]                     mstate;
  logic [cpu_pkg::tag_w-1:0]      want;
  logic [cpu_pkg::page_off_w-1:0] off_q;
  logic [cpu_pkg::ppage_w-1:0]    cur;
  logic [cpu_pkg::ppage_w-1:0]    probe;
  logic                           last_valid;
  logic [cpu_pkg::tag_w-1:0]      last_tag;
  logic [cpu_pkg::ppage_w-1:0]    last_page;
  logic [cpu_pkg::tag_w-1:0]      req_tag;

  assign req_tag       = {1'b0, map_req.laddr.page} + 1'b1;
  assign map_req_ready = (mstate == cpu_pkg::mp_idle);

  always_ff @(posedge clka) begin
    if (!rst || start) begin
      mstate         <= cpu_pkg::mp_idle;
      map_resp_valid <= 1'b0;
      last_valid     <= 1'b0;
      for (int i = 0; i < cpu_pkg::phys_pages; i++) begin
        chain[i] <= '0;
        tag[i]   <= (i == 0) ? cpu_pkg::tag_w'(1) : '0;  // logical page 0 lives in page 0
      end
    end else begin
      map_resp_valid <= 1'b0;
      case (mstate)
        cpu_pkg::mp_idle: begin
          if (map_req_valid) begin
            want  <= req_tag;
            off_q <= map_req.laddr.offset;
            if (last_valid && last_tag == req_tag) begin
              map_resp_valid <= 1'b1;  // same page as last time
              map_resp       <= '{phys_addr: {last_page, map_req.laddr.offset}, fault: 1'b0};
            end else begin
              cur    <= '0;
              mstate <= cpu_pkg::mp_walk;
            end
          end
        end
        cpu_pkg::mp_walk: begin
          if (tag[cur] == want) begin
            map_resp_valid <= 1'b1;
            map_resp       <= '{phys_addr: {cur, off_q}, fault: 1'b0};
            last_valid     <= 1'b1;
            last_tag       <= want;
            last_page      <= cur;
            mstate         <= cpu_pkg::mp_idle;
          end else if (chain[cur] == '0) begin
            probe  <= cpu_pkg::ppage_w'(1);  // end of chain, look for a free page
            mstate <= cpu_pkg::mp_probe;
          end else begin
            cur <= chain[cur];
          end
        end
        cpu_pkg::mp_probe: begin
          if (tag[probe] == '0) begin
            chain[cur]     <= probe;  // append to chain
            tag[probe]     <= want;
            map_resp_valid <= 1'b1;
            map_resp       <= '{phys_addr: {probe, off_q}, fault: 1'b0};
            last_valid     <= 1'b1;
            last_tag       <= want;
            last_page      <= probe;
            mstate         <= cpu_pkg::mp_idle;
          end else if (&probe) begin
            map_resp_valid <= 1'b1;  // out of pages
            map_resp       <= '{phys_addr: '0, fault: 1'b1};
            mstate         <= cpu_pkg::mp_idle;
          end else begin
            probe <= probe + 1'b1;
          end
        end
        default: mstate <= cpu_pkg::mp_idle;
      endcase
    end
  end

endmodule

/* design/loop_unit.sv */
module loop_unit (
  input  logic              clka,
  input  logic              rst,
  input  logic              start,
  input  logic              loop_arm,
  input  cpu_pkg::operand_t arm_operand,
  input  logic [1:0]        arm_kind,
  input  cpu_pkg::word_t    watched_value,
  input  logic              body_done,
  output logic              rewind,
  output cpu_pkg::word_t    rewind_words
);

  logic       active;
  logic [1:0] kind;
  logic [7:0] count;
  logic [7:0] remaining;  // comp_value, counts down for counted loops
  logic [7:0] body_cnt;
  logic       body_end;
  logic       cond;

  assign body_end     = active && body_done && (body_cnt + 8'd1 == count);
  assign rewind       = body_end && cond;
  assign rewind_words = {7'd0, count, 1'b0};  // two words per instruction

  always_comb begin
    case (kind)
      cpu_pkg::lk_till_value:     cond = (watched_value != {8'd0, remaining});
      cpu_pkg::lk_till_non_value: cond = (watched_value == {8'd0, remaining});
      cpu_pkg::lk_counted:        cond = (remaining != 8'd0);
      default:                    cond = 1'b0;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst || start) begin
      active    <= 1'b0;
      kind      <= cpu_pkg::lk_till_value;
      count     <= '0;
      remaining <= '0;
      body_cnt  <= '0;
    end else if (loop_arm) begin
      active    <= (arm_operand.loop.count != 8'd0);  // empty body never loops
      kind      <= arm_kind;
      count     <= arm_operand.loop.count;
      remaining <= arm_operand.loop.comp_value;
      body_cnt  <= '0;
    end else if (body_end) begin
      body_cnt <= '0;
      active   <= cond;
      if (cond && kind == cpu_pkg::lk_counted) begin
        remaining <= remaining - 8'd1;
      end
    end else if (active && body_done) begin
      body_cnt <= body_cnt + 8'd1;
    end
  end

endmodule

/* design/core_sequencer.sv */
module core_sequencer (
  input  logic                       clka,
  input  logic                       rst,
  input  logic                       start,
  output logic                       ram_en,
  output logic                       ram_we,
  output logic [cpu_pkg::addr_w-1:0] ram_addr,
  output cpu_pkg::word_t             ram_wdata,
  input  cpu_pkg::word_t             ram_rdata,
  output logic                       map_req_valid,
  input  logic                       map_req_ready,
  output cpu_pkg::map_req_t          map_req,
  input  logic                       map_resp_valid,
  input  cpu_pkg::map_resp_t         map_resp,
  output logic                       loop_arm,
  output cpu_pkg::operand_t          arm_operand,
  output logic [1:0]                 arm_kind,
  output cpu_pkg::word_t             watched_value,
  output logic                       body_done,
  input  logic                       rewind,
  input  cpu_pkg::word_t             rewind_words,
  output logic                       retire_valid,
  input  logic                       retire_ready,
  output cpu_pkg::retire_t           retire,
  output logic                       halted,
  output logic                       fault,
  output logic                       busy
);

  logic [2:0]                        state;
  logic [1:0]                        xkind;
  cpu_pkg::word_t                    pc;
  cpu_pkg::word_t                    pc_next;
  cpu_pkg::word_t                    xaddr;     // logical address being translated
  cpu_pkg::word_t                    result_q;
  cpu_pkg::inst_head_t               head;
  cpu_pkg::operand_t                 operand;
  logic [cpu_pkg::addr_w-1:0]        phys_q;
  logic [cpu_pkg::reg_sel_w-1:0]     rn;
  logic [cpu_pkg::reg_sel_w-1:0]     loop_reg;
  cpu_pkg::word_t                    regs [cpu_pkg::reg_count];
  logic                              reg_we;
  cpu_pkg::word_t                    reg_wd;
  logic                              is_loop;
  logic                              is_mem;
  logic                              handshake;

  assign rn        = head.reg_field[cpu_pkg::reg_sel_w-1:0];
  assign is_loop   = head.opcode inside {cpu_pkg::op_till_value, cpu_pkg::op_till_non_value,
                                         cpu_pkg::op_loop};
  assign is_mem    = head.opcode inside {cpu_pkg::op_ram2reg, cpu_pkg::op_reg2ram};
  assign handshake = retire_valid && retire_ready;

  assign map_req_valid = (state == cpu_pkg::st_xlate);
  assign map_req.laddr = xaddr;
  assign retire_valid  = (state == cpu_pkg::st_retire);
  assign halted        = (state == cpu_pkg::st_halt);
  assign busy          = !(state inside {cpu_pkg::st_idle, cpu_pkg::st_halt});

  assign loop_arm      = handshake && is_loop;
  assign body_done     = handshake && !is_loop;
  assign arm_operand   = operand;
  assign arm_kind      = head.opcode[1:0] - 2'd1;  // 9, 10, 11 map to kinds 0, 1, 2
  assign watched_value = regs[loop_reg];

  assign retire = '{pc: pc, opcode: head.opcode, reg_num: rn, result: result_q,
                    phys_addr: is_mem ? phys_q : '0};

  always_comb begin
    pc_next = pc + 16'd2;
    if (rewind) begin
      pc_next = pc + 16'd2 - rewind_words;  // back to first body instruction
    end else if (head.opcode == cpu_pkg::op_jmp) begin
      pc_next = operand.imm;
    end
  end

  // register file write port
  always_comb begin
    reg_we = 1'b0;
    reg_wd = operand.imm;
    if (state == cpu_pkg::st_exec) begin
      case (head.opcode)
        cpu_pkg::op_num2reg:   reg_we = 1'b1;
        cpu_pkg::op_reg_plus:  begin
          reg_we = 1'b1;
          reg_wd = regs[rn] + operand.imm;
        end
        cpu_pkg::op_reg_minus: begin
          reg_we = 1'b1;
          reg_wd = regs[rn] - operand.imm;
        end
        default:               reg_we = 1'b0;
      endcase
    end else if (state == cpu_pkg::st_load && xkind == cpu_pkg::xk_data &&
                 head.opcode == cpu_pkg::op_ram2reg) begin
      reg_we = 1'b1;
      reg_wd = ram_rdata;
    end
  end

  always_ff @(posedge clka) begin
    if (reg_we) begin
      regs[rn] <= reg_wd;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state    <= cpu_pkg::st_idle;
      xkind    <= cpu_pkg::xk_head;
      pc       <= '0;
      ram_en   <= 1'b0;
      ram_we   <= 1'b0;
      fault    <= 1'b0;
      loop_reg <= '0;
    end else begin
      if (loop_arm) begin
        loop_reg <= rn;  // register the loop watches
      end
      case (state)
        cpu_pkg::st_idle: begin
          if (start) begin
            pc    <= '0;
            xaddr <= '0;
            xkind <= cpu_pkg::xk_head;
            state <= cpu_pkg::st_xlate;
          end
        end
        cpu_pkg::st_xlate: begin
          if (map_req_ready) begin
            state <= cpu_pkg::st_xwait;
          end
        end
        cpu_pkg::st_xwait: begin
          if (map_resp_valid) begin
            if (map_resp.fault) begin
              fault <= 1'b1;
              state <= cpu_pkg::st_halt;
            end else begin
              ram_en    <= 1'b1;
              ram_we    <= (xkind == cpu_pkg::xk_data) && (head.opcode == cpu_pkg::op_reg2ram);
              ram_addr  <= map_resp.phys_addr;
              ram_wdata <= regs[rn];
              phys_q    <= map_resp.phys_addr;
              state     <= cpu_pkg::st_ram;
            end
          end
        end
        cpu_pkg::st_ram: begin
          ram_en <= 1'b0;
          ram_we <= 1'b0;
          state  <= cpu_pkg::st_load;
        end
        cpu_pkg::st_load: begin
          case (xkind)
            cpu_pkg::xk_head: begin
              head  <= ram_rdata;
              xaddr <= pc + 16'd1;
              xkind <= cpu_pkg::xk_opnd;
              state <= cpu_pkg::st_xlate;
            end
            cpu_pkg::xk_opnd: begin
              operand <= ram_rdata;
              state   <= cpu_pkg::st_exec;
            end
            default: begin
              result_q <= (head.opcode == cpu_pkg::op_ram2reg) ? ram_rdata : regs[rn];
              state    <= cpu_pkg::st_retire;
            end
          endcase
        end
        cpu_pkg::st_exec: begin
          if (is_mem) begin
            xaddr <= operand.imm;  // data address goes through the mapper
            xkind <= cpu_pkg::xk_data;
            state <= cpu_pkg::st_xlate;
          end else begin
            if (reg_we) begin
              result_q <= reg_wd;
            end else if (head.opcode == cpu_pkg::op_jmp) begin
              result_q <= operand.imm;
            end else begin
              result_q <= '0;
            end
            state <= cpu_pkg::st_retire;
          end
        end
        cpu_pkg::st_retire: begin
          if (retire_ready) begin
            if (head.opcode == cpu_pkg::op_exit) begin
              state <= cpu_pkg::st_halt;
            end else begin
              pc    <= pc_next;
              xaddr <= pc_next;
              xkind <= cpu_pkg::xk_head;
              state <= cpu_pkg::st_xlate;
            end
          end
        end
        default: state <= cpu_pkg::st_halt;  // halted until reset
      endcase
    end
  end

endmodule

/* design/cpu_top.sv */
module cpu_top (
  input  logic             clka,
  input  logic             rst,
  input  logic             load_valid,
  input  cpu_pkg::load_t   load,
  output logic             load_ready,
  input  logic             start,
  output logic             retire_valid,
  input  logic             retire_ready,
  output cpu_pkg::retire_t retire,
  output logic             halted,
  output logic             fault,
  output logic             busy
);

  logic                       ram_en;
  logic                       ram_we;
  logic [cpu_pkg::addr_w-1:0] ram_addr;
  cpu_pkg::word_t             ram_wdata;
  cpu_pkg::word_t             ram_rdata;
  logic                       map_req_valid;
  logic                       map_req_ready;
  cpu_pkg::map_req_t          map_req;
  logic                       map_resp_valid;
  cpu_pkg::map_resp_t         map_resp;
  logic                       loop_arm;
  cpu_pkg::operand_t          arm_operand;
  logic [1:0]                 arm_kind;
  cpu_pkg::word_t             watched_value;
  logic                       body_done;
  logic                       rewind;
  cpu_pkg::word_t             rewind_words;

  program_ram ram_inst (
    .clka, .rst, .busy, .load_valid, .load, .load_ready,
    .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

  page_mapper mapper_inst (
    .clka, .rst, .start, .map_req_valid, .map_req, .map_req_ready,
    .map_resp_valid, .map_resp
  );

  loop_unit loop_inst (
    .clka, .rst, .start, .loop_arm, .arm_operand, .arm_kind,
    .watched_value, .body_done, .rewind, .rewind_words
  );

  core_sequencer seq_inst (
    .clka, .rst, .start,
    .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata,
    .map_req_valid, .map_req_ready, .map_req, .map_resp_valid, .map_resp,
    .loop_arm, .arm_operand, .arm_kind, .watched_value, .body_done,
    .rewind, .rewind_words,
    .retire_valid, .retire_ready, .retire, .halted, .fault, .busy
  );

endmodule

/* tests/cpu_checker.sv */
module cpu_checker (
  input logic             clka,
  input logic             rst,
  input logic             retire_valid,
  input logic             retire_ready,
  input cpu_pkg::retire_t retire,
  input logic             halted,
  input logic             map_req_valid,
  input logic             map_req_ready,
  input logic             map_resp_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  logic req_open;  // accepted by the mapper, no answer yet

  always_ff @(posedge clka) begin
    if (!rst) begin
      req_open <= 1'b0;
    end else if (map_resp_valid) begin
      req_open <= 1'b0;
    end else if (map_req_valid && map_req_ready) begin
      req_open <= 1'b1;
    end
  end

  retire_stable: assert property (@(posedge clka) disable iff (!rst)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire))
    else $error("retire record changed while waiting for ready");

  halt_sticky: assert property (@(posedge clka) disable iff (!rst) halted |=> halted)
    else $error("halted fell without a reset");

  one_request: assert property (@(posedge clka) disable iff (!rst) req_open |-> !map_req_valid)
    else $error("new map request while one is still open");

endmodule

bind core_sequencer cpu_checker checker_inst (
  .clka, .rst, .retire_valid, .retire_ready, .retire, .halted,
  .map_req_valid, .map_req_ready, .map_resp_valid
);

/* tests/cpu_tb.sv */
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic             clka;
  logic             rst;
  logic             load_valid;
  cpu_pkg::load_t   load;
  logic             load_ready;
  logic             start;
  logic             retire_valid;
  logic             retire_ready;
  cpu_pkg::retire_t retire;
  logic             halted;
  logic             fault;
  logic             busy;

  logic [55:0]      golden [256];  // kind nibble above the payload
  int               cycles;
  int               limit;

  cpu_top cpu_inst (
    .clka, .rst, .load_valid, .load, .load_ready, .start,
    .retire_valid, .retire_ready, .retire, .halted, .fault, .busy
  );

  initial begin
    clka = 1'b0;
    forever #20 clka = ~clka;
  end

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped by the watchdog");
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_retire(input string name, input cpu_pkg::retire_t exp,
                              input cpu_pkg::retire_t act);
    if (act !== exp) begin
      report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input logic exp_halted, input logic exp_fault,
                              input logic act_halted, input logic act_fault);
    if (act_halted !== exp_halted || act_fault !== exp_fault) begin
      report_failure($sformatf(
          "[ERROR] %s: expected halted=%b fault=%b, actual halted=%b fault=%b",
          name, exp_halted, exp_fault, act_halted, act_fault));
    end
  endtask

  task automatic apply_reset();
    @(posedge clka);
    rst          <= 1'b0;
    load_valid   <= 1'b0;
    start        <= 1'b0;
    retire_ready <= 1'b0;
    repeat (8) @(posedge clka);
    rst <= 1'b1;
  endtask

  task automatic write_word(input cpu_pkg::load_t w);
    @(posedge clka);
    load_valid <= 1'b1;
    load       <= w;
    do begin
      @(negedge clka);
    end while (!load_ready);  // taken on the next rising edge
  endtask

  task automatic pulse_start();
    @(posedge clka);
    load_valid <= 1'b0;
    start      <= 1'b1;
    @(posedge clka);
    start <= 1'b0;
  endtask

  task automatic expect_retire(input string name, input cpu_pkg::retire_t exp);
    do begin
      @(posedge clka);
      retire_ready <= ($urandom % 4) != 0;  // random back-pressure
      @(negedge clka);
    end while (!(retire_valid && retire_ready));
    check_retire(name, exp, retire);
  endtask

  task automatic expect_halt(input string name, input logic exp_halted, input logic exp_fault);
    do begin
      @(posedge clka);
      retire_ready <= ($urandom % 4) != 0;
      @(negedge clka);
      if (retire_valid) begin
        report_failure($sformatf("%s: a retire record came out before the core halted", name));
      end
    end while (busy);  // busy falls when the core stops
    check_status(name, exp_halted, exp_fault, halted, fault);
    repeat (10) begin
      @(negedge clka);
      if (retire_valid) begin
        report_failure($sformatf("%s: a retire record came out after the halt", name));
      end
    end
  endtask

  initial begin
    int    idx;
    int    prog;
    int    records;
    int    loads;
    string name;
    void'($urandom(18));
    rst          = 1'b0;
    load_valid   = 1'b0;
    load         = '0;
    start        = 1'b0;
    retire_ready = 1'b0;
    limit        = 0;
    prog         = 0;
    records      = 0;
    loads        = 0;
    $readmemh("tests/cpu_golden.mem", golden);
    for (idx = 0; idx < 256 && golden[idx][55:52] !== 4'hf; idx++) begin
      if (golden[idx][55:52] == 4'h1) loads++;
      if (golden[idx][55:52] == 4'h3 || golden[idx][55:52] == 4'h4) records++;
    end
    limit = 400 * records + loads;
    apply_reset();
    idx = 0;
    while (golden[idx][55:52] !== 4'hf) begin
      name = $sformatf("program %0d entry %0d", prog, idx);
      case (golden[idx][55:52])
        4'h1: write_word(golden[idx][23:0]);
        4'h2: begin
          prog++;
          pulse_start();
        end
        4'h3: expect_retire(name, golden[idx][51:0]);
        4'h4: expect_halt(name, golden[idx][1], golden[idx][0]);
        4'h5: apply_reset();
        default: report_failure($sformatf("golden file entry %0d has an unknown kind", idx));
      endcase
      idx++;
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tests/cpu_golden.mem */
// kind nibble, then payload: 1 load {addr, data}, 2 start, 3 retire {pc, op, reg, result, phys}
// 4 halt {halted, fault}, 5 reset, f end
// program 1: arithmetic, store and load on logical page 3, jump, two loops, page 5, exit
10000000000401 10000000010005 10000000020501 10000000030003
10000000040601 10000000050001 10000000060301 10000000070064
10000000080202 10000000090064 100000000A0100 100000000B000E
100000000C0409 100000000DDEAD 100000000E0403 100000000F0000
10000000100B00 10000000110201 10000000120503 10000000130001
10000000140903 10000000150601 10000000160503 10000000170001
10000000180303 100000001900A2 100000001A1100 100000001B0000
20000000000000
30000041000500
30002051000800
30004061000700
30006031000724
30008022000724
3000A010000E00
3000E043000000
300100B0000000
30012053000100
30012053000200
30012053000300
30014093000000
30016053000400
30016053000500
30016053000600
30018033000642
3001A110000000
40000000000002
// program 2: stores to logical pages 1 to 8, the eighth new page finds no free page
50000000000000
10000000000401 100000000100AA 10000000020301 10000000030020
10000000040301 10000000050040 10000000060301 10000000070060
10000000080301 10000000090080 100000000A0301 100000000B00A0
100000000C0301 100000000D00C0 100000000E0301 100000000F00E0
10000000100301 10000000110100
20000000000000
3000004100AA00
3000203100AA20
3000403100AA40
3000603100AA60
3000803100AA80
3000A03100AAA0
3000C03100AAC0
3000E03100AAE0
40000000000003
F0000000000000

/* sim.f */
design/cpu_pkg.sv
design/program_ram.sv
design/page_mapper.sv
design/loop_unit.sv
design/core_sequencer.sv
design/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module cpu_tb -f sim.f -o cpu_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/cpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
